// File: filelist.f
+incdir+source
source/game_pkg.sv
source/video_pkg.sv
source/ship_ctl.sv
source/hit_detect.sv
source/missile_ctl.sv
source/ship_draw.sv
source/missile_draw.sv
source/layer_mixer.sv
source/ship_layer.sv
tb/ship_layer_assertions.sv
tb/ship_layer_tb.sv

// File: Makefile
SIM = obj_dir/Vship_layer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module ship_layer_tb \
	  -f filelist.f -Mdir obj_dir

run: compile
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb/ship_layer_tb.sv
`include "game_params.svh"

module ship_layer_tb
  import game_pkg::*;
  import video_pkg::*;
;

  localparam int     TIMEOUT = 20;
  localparam coord_t X_MAX   = coord_t'(`SCREEN_W - `SHIP_W);

  logic     pclk;
  logic     reset_i;
  vtiming_t timing_i;
  rgb_t     rgb_i;
  logic     left_i;
  logic     right_i;
  logic     fire_i;
  coord_t   enemy_x_i [3];
  coord_t   enemy_y_i [3];
  vtiming_t timing_o;
  rgb_t     rgb_o;
  coord_t   missile_x_o;
  coord_t   missile_y_o;
  logic     missile_on_o;
  lives_t   lives_o;

  int err_cnt;
  int chk_cnt;

  ship_layer ship_layer_i (.*);

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  task automatic abort_on_timeout(input string what);
    $display("timeout: no response from the DUT while waiting for %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s colour %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_coord(input coord_t got, input coord_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_lives(input lives_t got, input lives_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // one vsync pulse, returns once the edge has come out of the pipe
  task automatic frame();
    int n;
    timing_i.vsync = 1'b1;
    n = 0;
    do begin
      @(negedge pclk);
      n++;
    end while (!timing_o.vsync && n < TIMEOUT);
    if (!timing_o.vsync) abort_on_timeout("vsync high on timing_o");
    timing_i.vsync = 1'b0;
    n = 0;
    do begin
      @(negedge pclk);
      n++;
    end while (timing_o.vsync && n < TIMEOUT);
    if (timing_o.vsync) abort_on_timeout("vsync low on timing_o");
  endtask

  // pixel pipe is 2 cycles deep
  task automatic pixel(input coord_t x, input coord_t y, input logic blank,
                       output rgb_t in_c, output rgb_t out_c);
    timing_i.hcount = x;
    timing_i.vcount = y;
    timing_i.hblnk  = blank;
    timing_i.vblnk  = 1'b0;
    in_c  = rgb_t'($urandom);
    rgb_i = in_c;
    for (int i = 0; i < 2; i++) @(negedge pclk);
    out_c = rgb_o;
  endtask

  task automatic clear_enemies();
    for (int i = 0; i < 3; i++) begin
      enemy_x_i[i] = '0;
      enemy_y_i[i] = '0;
    end
  endtask

  // left edge of the ship at x, nothing just left of it
  task automatic ship_edge_at(input coord_t x, input string what);
    rgb_t in_c;
    rgb_t out_c;
    pixel(x, coord_t'(`SHIP_Y), 1'b0, in_c, out_c);
    check_rgb(out_c, `SHIP_RGB, what);
    pixel(x - 1'b1, coord_t'(`SHIP_Y + `SHIP_H - 1), 1'b0, in_c, out_c);
    check_rgb(out_c, in_c, what);
  endtask

  task automatic life_markers(input lives_t n);
    rgb_t in_c;
    rgb_t out_c;
    for (int k = 0; k < `LIVES_START; k++) begin
      pixel(coord_t'(`LIFE_X + k * `LIFE_GAP + `LIFE_SIZE - 1),
            coord_t'(`LIFE_Y + `LIFE_SIZE / 2), 1'b0, in_c, out_c);
      check_rgb(out_c, (k < n) ? rgb_t'(`LIFE_RGB) : in_c, "life marker");
    end
    // gap right of the first marker
    pixel(coord_t'(`LIFE_X + `LIFE_SIZE), coord_t'(`LIFE_Y), 1'b0, in_c, out_c);
    check_rgb(out_c, in_c, "marker gap");
  endtask

  task automatic after_reset();
    rgb_t in_c;
    rgb_t out_c;
    ship_edge_at(coord_t'(`SHIP_X_RESET), "ship at reset");
    check_bit(missile_on_o, 1'b0, "missile on at reset");
    check_lives(lives_o, lives_t'(`LIVES_START), "lives at reset");
    life_markers(lives_t'(`LIVES_START));
    pixel(coord_t'(`SHIP_X_RESET), coord_t'(`SHIP_Y), 1'b1, in_c, out_c);
    check_rgb(out_c, '0, "blanked pixel");
  endtask

  task automatic ship_movement();
    right_i = 1'b1;
    for (int i = 0; i < 10; i++) frame();
    ship_edge_at(coord_t'(`SHIP_X_RESET + 10 * `SHIP_STEP), "ship after 10 steps");
    // both pressed away from the edges
    left_i = 1'b1;
    for (int i = 0; i < 3; i++) frame();
    ship_edge_at(coord_t'(`SHIP_X_RESET + 10 * `SHIP_STEP), "ship with both buttons");
    left_i = 1'b0;
    // far more steps than needed to reach the right edge
    for (int i = 0; i < 130; i++) frame();
    ship_edge_at(X_MAX, "ship clamped right");
    right_i = 1'b0;
  endtask

  task automatic missile_flight();
    rgb_t   in_c;
    rgb_t   out_c;
    coord_t exp_x;
    coord_t exp_y;
    logic   exp_on;
    int     n;
    exp_x  = X_MAX + coord_t'(`SHIP_W / 2 - 1);
    exp_y  = coord_t'(`SHIP_Y - `MISSILE_LEN);
    exp_on = 1'b1;
    fire_i = 1'b1;
    frame();
    fire_i = 1'b0;
    check_bit(missile_on_o, 1'b1, "missile on after fire");
    check_coord(missile_x_o, exp_x, "missile x at launch");
    check_coord(missile_y_o, exp_y, "missile y at launch");
    pixel(exp_x, exp_y, 1'b0, in_c, out_c);
    check_rgb(out_c, `MISSILE_RGB, "missile pixel");
    pixel(exp_x + coord_t'(`MISSILE_W), exp_y, 1'b0, in_c, out_c);
    check_rgb(out_c, in_c, "right of missile");
    pixel(exp_x, exp_y + coord_t'(`MISSILE_LEN), 1'b0, in_c, out_c);
    check_rgb(out_c, `SHIP_RGB, "ship below missile");
    // second press in flight
    fire_i = 1'b1;
    n = 0;
    while (missile_on_o && n < 200) begin
      if (exp_y < coord_t'(`MISSILE_STEP)) begin
        exp_on = 1'b0;
      end else begin
        exp_y = exp_y - coord_t'(`MISSILE_STEP);
      end
      frame();
      fire_i = 1'b0;
      check_bit(missile_on_o, exp_on, "missile on in flight");
      if (exp_on) begin
        check_coord(missile_y_o, exp_y, "missile y in flight");
        check_coord(missile_x_o, exp_x, "missile x in flight");
      end
      n++;
    end
    if (missile_on_o) abort_on_timeout("missile expiry");
  endtask

  task automatic hit_and_lockout();
    enemy_x_i[1] = X_MAX + 8;
    enemy_y_i[1] = coord_t'(`SHIP_Y + 5);
    frame();
    clear_enemies();
    check_lives(lives_o, 2'd2, "lives after first hit");
    life_markers(2'd2);
    left_i = 1'b1;
    fire_i = 1'b1;
    for (int i = 0; i < `LOCK_FRAMES; i++) begin
      frame();
      check_bit(missile_on_o, 1'b0, "missile during lockout");
    end
    ship_edge_at(X_MAX, "ship frozen in lockout");
    frame();
    ship_edge_at(X_MAX - coord_t'(`SHIP_STEP), "ship after lockout");
    check_bit(missile_on_o, 1'b1, "missile after lockout");
    left_i = 1'b0;
    fire_i = 1'b0;
    // misses never touch the ship box
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 3; i++) begin
        enemy_x_i[i] = coord_t'($urandom % `SCREEN_W);
        enemy_y_i[i] = coord_t'($urandom % `SHIP_Y);
      end
      frame();
      check_lives(lives_o, 2'd2, "lives after a miss");
    end
    clear_enemies();
  endtask

  task automatic game_over();
    rgb_t   in_c;
    rgb_t   out_c;
    coord_t x;
    int     n;
    x = X_MAX - coord_t'(`SHIP_STEP);
    enemy_x_i[0] = x;
    enemy_y_i[0] = coord_t'(`SHIP_Y);
    frame();
    clear_enemies();
    check_lives(lives_o, 2'd1, "lives after second hit");
    for (int i = 0; i < `LOCK_FRAMES; i++) frame();
    enemy_x_i[2] = x + coord_t'(`SHIP_W - 1);
    enemy_y_i[2] = coord_t'(`SHIP_Y + `SHIP_H - 1);
    frame();
    clear_enemies();
    check_lives(lives_o, 2'd0, "lives after third hit");
    life_markers(2'd0);
    pixel(x, coord_t'(`SHIP_Y), 1'b0, in_c, out_c);
    check_rgb(out_c, in_c, "ship gone");
    n = 0;
    while (missile_on_o && n < 200) begin
      frame();
      n++;
    end
    if (missile_on_o) abort_on_timeout("missile expiry before game over checks");
    right_i = 1'b1;
    fire_i  = 1'b1;
    // enemy still inside the box, no further life lost
    enemy_x_i[0] = x;
    enemy_y_i[0] = coord_t'(`SHIP_Y);
    for (int i = 0; i < 5; i++) begin
      frame();
      check_bit(missile_on_o, 1'b0, "missile after game over");
    end
    check_coord(ship_layer_i.ship_x, x, "ship x after game over");
    check_lives(lives_o, 2'd0, "lives after game over");
    clear_enemies();
    right_i = 1'b0;
    fire_i  = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h1d72_3972));
    err_cnt  = 0;
    chk_cnt  = 0;
    reset_i  = 1'b1;
    timing_i = '0;
    rgb_i    = '0;
    left_i   = 1'b0;
    right_i  = 1'b0;
    fire_i   = 1'b0;
    clear_enemies();
    for (int i = 0; i < 8; i++) @(negedge pclk);
    reset_i = 1'b0;

    after_reset();
    ship_movement();
    missile_flight();
    hit_and_lockout();
    game_over();

    $display("errors: %0d in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb/ship_layer_assertions.sv
module ship_layer_assertions
  import game_pkg::*;
  import video_pkg::*;
(
  input logic     pclk,
  input logic     reset_i,
  input vtiming_t timing_i,
  input vtiming_t timing_o,
  input logic     missile_on_o,
  input lives_t   lives_o
);

  // no missile in the cycle after a reset
  missile_off_after_reset: assert property (@(posedge pclk) reset_i |=> !missile_on_o)
    else $error("missile on right after reset");

  // two register stages on the raster path
  timing_two_cycles: assert property (@(posedge pclk) disable iff (reset_i)
    (!$past(reset_i) && !$past(reset_i, 2)) |-> timing_o == $past(timing_i, 2))
    else $error("timing_o is not timing_i delayed by two cycles");

  lives_never_grow: assert property (@(posedge pclk) disable iff (reset_i)
    !$past(reset_i) |-> lives_o <= $past(lives_o))
    else $error("lives went up without a reset");

endmodule

bind ship_layer ship_layer_assertions u_ship_layer_assertions (
  .pclk         (pclk),
  .reset_i      (reset_i),
  .timing_i     (timing_i),
  .timing_o     (timing_o),
  .missile_on_o (missile_on_o),
  .lives_o      (lives_o)
);

// File: source/ship_layer.sv
module ship_layer
  import game_pkg::*;
  import video_pkg::*;
(
  input  logic     pclk,
  input  logic     reset_i,
  input  vtiming_t timing_i,
  input  rgb_t     rgb_i,
  input  logic     left_i,
  input  logic     right_i,
  input  logic     fire_i,
  input  coord_t   enemy_x_i [3],
  input  coord_t   enemy_y_i [3],
  output vtiming_t timing_o,
  output rgb_t     rgb_o,
  output coord_t   missile_x_o,
  output coord_t   missile_y_o,
  output logic     missile_on_o,
  output lives_t   lives_o
);

  logic        frame_tick;
  coord_t      ship_x;
  ship_state_t ship_state;
  lives_t      lives;
  coord_t      missile_x;
  coord_t      missile_y;
  logic        missile_on;
  layer_t      ship_layer;
  layer_t      missile_layer;

  // game state, updated once per frame
  ship_ctl u_ship_ctl (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .timing_i     (timing_i),
    .left_i       (left_i),
    .right_i      (right_i),
    .ship_state_i (ship_state),
    .frame_tick_o (frame_tick),
    .ship_x_o     (ship_x)
  );

  hit_detect u_hit_detect (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .frame_tick_i (frame_tick),
    .ship_x_i     (ship_x),
    .enemy_x_i    (enemy_x_i),
    .enemy_y_i    (enemy_y_i),
    .ship_state_o (ship_state),
    .lives_o      (lives)
  );

  missile_ctl u_missile_ctl (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .frame_tick_i (frame_tick),
    .fire_i       (fire_i),
    .ship_x_i     (ship_x),
    .ship_state_i (ship_state),
    .missile_x_o  (missile_x),
    .missile_y_o  (missile_y),
    .missile_on_o (missile_on)
  );

  // painters, one cycle each
  ship_draw u_ship_draw (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .timing_i     (timing_i),
    .ship_x_i     (ship_x),
    .ship_state_i (ship_state),
    .layer_o      (ship_layer)
  );

  missile_draw u_missile_draw (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .timing_i     (timing_i),
    .missile_x_i  (missile_x),
    .missile_y_i  (missile_y),
    .missile_on_i (missile_on),
    .layer_o      (missile_layer)
  );

  layer_mixer u_layer_mixer (
    .pclk            (pclk),
    .reset_i         (reset_i),
    .timing_i        (timing_i),
    .rgb_i           (rgb_i),
    .lives_i         (lives),
    .ship_layer_i    (ship_layer),
    .missile_layer_i (missile_layer),
    .timing_o        (timing_o),
    .rgb_o           (rgb_o)
  );

  assign missile_x_o  = missile_x;
  assign missile_y_o  = missile_y;
  assign missile_on_o = missile_on;
  assign lives_o      = lives;

endmodule

// File: source/layer_mixer.sv
`include "game_params.svh"

module layer_mixer
  import game_pkg::*;
  import video_pkg::*;
(
  input  logic     pclk,
  input  logic     reset_i,
  input  vtiming_t timing_i,
  input  rgb_t     rgb_i,
  input  lives_t   lives_i,
  input  layer_t   ship_layer_i,
  input  layer_t   missile_layer_i,
  output vtiming_t timing_o,
  output rgb_t     rgb_o
);

  vtiming_t timing_d1;
  rgb_t     rgb_d1;
  vtiming_t timing_d2;
  rgb_t     rgb_d2;
  logic     life_hit;

  // stage 1, line up with the painter registers
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      timing_d1 <= '0;
      rgb_d1    <= '0;
    end else begin
      timing_d1 <= timing_i;
      rgb_d1    <= rgb_i;
    end
  end

  // one square per remaining life, on the delayed pixel
  always_comb begin
    life_hit = 1'b0;
    for (int k = 0; k < `LIVES_START; k++) begin
      if (k < lives_i &&
          timing_d1.hcount >= `LIFE_X + k * `LIFE_GAP &&
          timing_d1.hcount < `LIFE_X + k * `LIFE_GAP + `LIFE_SIZE &&
          timing_d1.vcount >= `LIFE_Y &&
          timing_d1.vcount < `LIFE_Y + `LIFE_SIZE) begin
        life_hit = 1'b1;
      end
    end
  end

  // stage 2, blanking first, then missile over ship over markers
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      timing_d2 <= '0;
      rgb_d2    <= '0;
    end else begin
      timing_d2 <= timing_d1;
      if (timing_d1.hblnk || timing_d1.vblnk) begin
        rgb_d2 <= '0;
      end else if (missile_layer_i.hit) begin
        rgb_d2 <= missile_layer_i.rgb;
      end else if (ship_layer_i.hit) begin
        rgb_d2 <= ship_layer_i.rgb;
      end else if (life_hit) begin
        rgb_d2 <= `LIFE_RGB;
      end else begin
        rgb_d2 <= rgb_d1;
      end
    end
  end

  assign timing_o = timing_d2;
  assign rgb_o    = rgb_d2;

endmodule

// File: source/missile_draw.sv
`include "game_params.svh"

module missile_draw
  import game_pkg::*;
  import video_pkg::*;
(
  input  logic     pclk,
  input  logic     reset_i,
  input  vtiming_t timing_i,
  input  coord_t   missile_x_i,
  input  coord_t   missile_y_i,
  input  logic     missile_on_i,
  output layer_t   layer_o
);

  logic   in_bar;
  layer_t layer_q;

  // narrow vertical bar, top left at missile x,y
  always_comb begin
    in_bar = (timing_i.hcount >= missile_x_i) &&
             (timing_i.hcount < missile_x_i + `MISSILE_W) &&
             (timing_i.vcount >= missile_y_i) &&
             (timing_i.vcount < missile_y_i + `MISSILE_LEN);
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      layer_q <= '0;
    end else begin
      layer_q.hit <= missile_on_i && in_bar;
      layer_q.rgb <= `MISSILE_RGB;
    end
  end

  assign layer_o = layer_q;

endmodule

// File: source/ship_draw.sv
`include "game_params.svh"

module ship_draw
  import game_pkg::*;
  import video_pkg::*;
(
  input  logic        pclk,
  input  logic        reset_i,
  input  vtiming_t    timing_i,
  input  coord_t      ship_x_i,
  input  ship_state_t ship_state_i,
  output layer_t      layer_o
);

  logic   in_box;
  layer_t layer_q;

  // ship stays visible while locked
  always_comb begin
    in_box = (timing_i.hcount >= ship_x_i) &&
             (timing_i.hcount <= ship_x_i + `SHIP_W - 1) &&
             (timing_i.vcount >= `SHIP_Y) &&
             (timing_i.vcount <= `SHIP_Y + `SHIP_H - 1);
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      layer_q <= '0;
    end else begin
      layer_q.hit <= in_box && (ship_state_i != SHIP_OVER);
      layer_q.rgb <= `SHIP_RGB;
    end
  end

  assign layer_o = layer_q;

endmodule

// File: source/missile_ctl.sv
`include "game_params.svh"

module missile_ctl
  import game_pkg::*;
(
  input  logic        pclk,
  input  logic        reset_i,
  input  logic        frame_tick_i,
  input  logic        fire_i,
  input  coord_t      ship_x_i,
  input  ship_state_t ship_state_i,
  output coord_t      missile_x_o,
  output coord_t      missile_y_o,
  output logic        missile_on_o
);

  localparam coord_t STEP    = coord_t'(`MISSILE_STEP);
  localparam coord_t START_Y = coord_t'(`SHIP_Y - `MISSILE_LEN);

  missile_state_t state;
  coord_t         missile_x;
  coord_t         missile_y;

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      state <= MISSILE_IDLE;
    end else if (frame_tick_i) begin
      case (state)
        MISSILE_IDLE: begin
          if (fire_i && ship_state_i == SHIP_ALIVE) begin
            state <= MISSILE_FLY;
          end
        end
        MISSILE_FLY: begin
          // next step would leave the top of the screen
          if (missile_y < STEP) begin
            state <= MISSILE_IDLE;
          end
        end
        default: begin
          state <= MISSILE_IDLE;
        end
      endcase
    end
  end

  // position, centred on the ship at launch
  always_ff @(posedge pclk) begin
    if (frame_tick_i) begin
      if (state == MISSILE_IDLE) begin
        missile_x <= ship_x_i + coord_t'(`SHIP_W / 2 - 1);
        missile_y <= START_Y;
      end else if (missile_y >= STEP) begin
        missile_y <= missile_y - STEP;
      end
    end
  end

  assign missile_x_o  = missile_x;
  assign missile_y_o  = missile_y;
  assign missile_on_o = (state == MISSILE_FLY);

endmodule

// File: source/hit_detect.sv
`include "game_params.svh"

module hit_detect
  import game_pkg::*;
(
  input  logic        pclk,
  input  logic        reset_i,
  input  logic        frame_tick_i,
  input  coord_t      ship_x_i,
  input  coord_t      enemy_x_i [3],
  input  coord_t      enemy_y_i [3],
  output ship_state_t ship_state_o,
  output lives_t      lives_o
);

  localparam int LOCK_W = $clog2(`LOCK_FRAMES);

  typedef logic [LOCK_W-1:0] lock_cnt_t;

  ship_state_t state;
  lives_t      lives;
  lock_cnt_t   lock_cnt;
  logic        enemy_hit;

  // any enemy missile inside the ship box
  always_comb begin
    enemy_hit = 1'b0;
    for (int i = 0; i < $size(enemy_x_i); i++) begin
      if (enemy_x_i[i] >= ship_x_i &&
          enemy_x_i[i] <= ship_x_i + `SHIP_W - 1 &&
          enemy_y_i[i] >= `SHIP_Y &&
          enemy_y_i[i] <= `SHIP_Y + `SHIP_H - 1) begin
        enemy_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      state    <= SHIP_ALIVE;
      lives    <= lives_t'(`LIVES_START);
      lock_cnt <= '0;
    end else if (frame_tick_i) begin
      case (state)
        SHIP_ALIVE: begin
          if (enemy_hit) begin
            lives <= lives - 1'b1;
            // last life gone
            if (lives == lives_t'(1)) begin
              state <= SHIP_OVER;
            end else begin
              state    <= SHIP_LOCKED;
              lock_cnt <= lock_cnt_t'(`LOCK_FRAMES - 1);
            end
          end
        end
        SHIP_LOCKED: begin
          // counts LOCK_FRAMES ticks including the one that releases
          if (lock_cnt == '0) begin
            state <= SHIP_ALIVE;
          end else begin
            lock_cnt <= lock_cnt - 1'b1;
          end
        end
        default: begin
          state <= SHIP_OVER;
        end
      endcase
    end
  end

  assign ship_state_o = state;
  assign lives_o      = lives;

endmodule

// File: source/ship_ctl.sv
`include "game_params.svh"

module ship_ctl
  import game_pkg::*;
  import video_pkg::*;
(
  input  logic        pclk,
  input  logic        reset_i,
  input  vtiming_t    timing_i,
  input  logic        left_i,
  input  logic        right_i,
  input  ship_state_t ship_state_i,
  output logic        frame_tick_o,
  output coord_t      ship_x_o
);

  localparam coord_t X_MAX = coord_t'(`SCREEN_W - `SHIP_W);
  localparam coord_t STEP  = coord_t'(`SHIP_STEP);

  logic   vsync_d;
  logic   frame_tick;
  coord_t ship_x;
  coord_t ship_x_nxt;

  // tick comes one cycle after the vsync rising edge
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vsync_d    <= 1'b0;
      frame_tick <= 1'b0;
    end else begin
      vsync_d    <= timing_i.vsync;
      frame_tick <= timing_i.vsync & ~vsync_d;
    end
  end

  // one step per frame, both buttons cancel out
  always_comb begin
    ship_x_nxt = ship_x;
    if (left_i && !right_i) begin
      if (ship_x < STEP) begin
        ship_x_nxt = '0;
      end else begin
        ship_x_nxt = ship_x - STEP;
      end
    end else if (right_i && !left_i) begin
      if (ship_x > X_MAX - STEP) begin
        ship_x_nxt = X_MAX;
      end else begin
        ship_x_nxt = ship_x + STEP;
      end
    end
  end

  // frozen while locked or over
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      ship_x <= coord_t'(`SHIP_X_RESET);
    end else if (frame_tick && ship_state_i == SHIP_ALIVE) begin
      ship_x <= ship_x_nxt;
    end
  end

  assign frame_tick_o = frame_tick;
  assign ship_x_o     = ship_x;

endmodule

// File: source/video_pkg.sv
package video_pkg;
  import game_pkg::*;

  // 4 bits per channel, r g b
  typedef logic [11:0] rgb_t;

  // raster timing for one pixel
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   hblnk;
    logic   vsync;
    logic   vblnk;
  } vtiming_t;

  // output of a painter for one pixel
  typedef struct packed {
    logic hit;
    rgb_t rgb;
  } layer_t;

endpackage

// File: source/game_pkg.sv
package game_pkg;

  // pixel coordinate, wide enough for 1024 plus margin
  typedef logic [10:0] coord_t;

  // remaining lives
  typedef logic [1:0] lives_t;

  // ship condition as seen by movement, firing and drawing
  typedef enum logic [1:0] {
    SHIP_ALIVE,
    SHIP_LOCKED,
    // no more lives, only reset leaves this
    SHIP_OVER
  } ship_state_t;

  // player missile
  typedef enum logic {
    MISSILE_IDLE,
    MISSILE_FLY
  } missile_state_t;

endpackage

// File: source/game_params.svh
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// visible area
`define SCREEN_W      1024
`define SCREEN_H      768

// ship rectangle, top row fixed near the bottom
`define SHIP_Y        700
`define SHIP_W        32
`define SHIP_H        16
`define SHIP_X_RESET  496
`define SHIP_STEP     4

// player missile bar
`define MISSILE_W     2
`define MISSILE_LEN   8
`define MISSILE_STEP  8

// lives and hit lockout in frames
`define LIVES_START   3
`define LOCK_FRAMES   60

// life marker row, top left corner
`define LIFE_X        30
`define LIFE_Y        50
`define LIFE_SIZE     16
`define LIFE_GAP      24

`define SHIP_RGB      12'h0_f_0
`define MISSILE_RGB   12'hf_f_0
`define LIFE_RGB      12'hf_0_0

`endif
